/* rtl/dzPkg.sv */
// DZ11-style transmit multiplexer shared definitions
// Register map, CSR bit positions, line count and bus/transmit structs

package dzPkg;

   ////////////////////////////////////////
   // Line configuration
   ////////////////////////////////////////

   // Eight serial lines
   localparam int numLines = 8;
   localparam int lineW    = 3;

   // Busy time per character, in clock cycles
   localparam int charTime = 8;
   // Busy counter wide enough to hold charTime
   localparam int cntW     = $clog2(charTime + 1);

   ////////////////////////////////////////
   // Register map (word offsets)
   ////////////////////////////////////////

   localparam logic [1:0] regCsr = 2'd0;
   // Offset 1 unused, reads as zero
   localparam logic [1:0] regTcr = 2'd2;
   // TDR is write only
   localparam logic [1:0] regTdr = 2'd3;

   // CSR bit positions
   localparam int csrClrBit   = 4;
   localparam int csrMseBit   = 5;
   localparam int csrTlineLsb = 8;
   localparam int csrTieBit   = 14;
   localparam int csrTrdyBit  = 15;

   ////////////////////////////////////////
   // Bus and datapath structs
   ////////////////////////////////////////

   // Bus request, 16-bit little-endian
   typedef struct packed {
      logic        wr;
      logic        rd;
      logic        lo;
      logic        hi;
      logic [1:0]  addr;
      logic [15:0] data;
   } dzBusReq;

   // Decoded register write strobes with byte lanes and data
   typedef struct packed {
      logic        csrWr;
      logic        tcrWr;
      logic        tdrWr;
      logic        lo;
      logic        hi;
      logic [15:0] data;
   } dzWrStrobes;

   // Transmitted character strobe
   typedef struct packed {
      logic             valid;
      logic [lineW-1:0] line;
      logic [7:0]       chr;
   } dzTxChar;

   // Scanner status for the CSR read value
   typedef struct packed {
      logic             trdy;
      logic [lineW-1:0] tline;
   } dzScanStat;

endpackage

/* rtl/dzDecode.sv */
// DZ11 bus decoder
// Turns a bus request into register write strobes and muxes read data

`timescale 1ns/1ns

module dzDecode import dzPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  dzBusReq     busReq,
   input  logic [15:0] regCsr,
   input  logic [15:0] regTcr,
   output dzWrStrobes  wrStb,
   output logic [15:0] rdData
);

   ////////////////////////////////////////
   // Reset recovery
   ////////////////////////////////////////

   // Bus writes accepted only once out of reset
   // First clock after reset release arms the decoder
   logic busEn;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busEn <= 1'b0;
      end
      else
      begin
         busEn <= 1'b1;
      end
   end

   ////////////////////////////////////////
   // Write strobes
   ////////////////////////////////////////

   logic wrOk;

   // Write qualified by armed decoder
   assign wrOk = busReq.wr & busEn;

   // Register offsets come from the package, the ports carry register values
   always_comb
   begin
      wrStb.csrWr = wrOk && (busReq.addr == dzPkg::regCsr);
      wrStb.tcrWr = wrOk && (busReq.addr == dzPkg::regTcr);
      wrStb.tdrWr = wrOk && (busReq.addr == regTdr);
      // Byte lanes and data pass straight to the registers
      wrStb.lo    = busReq.lo;
      wrStb.hi    = busReq.hi;
      wrStb.data  = busReq.data;
   end

   ////////////////////////////////////////
   // Read multiplexer
   ////////////////////////////////////////

   // Combinational from the registers and zero when not reading
   always_comb
   begin
      rdData = 16'h0000;
      if (busReq.rd)
      begin
         case (busReq.addr)
            dzPkg::regCsr: rdData = regCsr;
            dzPkg::regTcr: rdData = regTcr;
            // TDR and unused offset read zero
            default:       rdData = 16'h0000;
         endcase
      end
   end

endmodule

/* rtl/dzCsr.sv */
// DZ11 Control and Status Register
// Holds MSE and TIE, makes the CLR pulse, reports TRDY/TLINE and the irq

`timescale 1ns/1ns

module dzCsr import dzPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        devReset,
   input  dzWrStrobes  wrStb,
   input  dzScanStat   scan,
   output logic [15:0] regCsr,
   output logic        mse,
   output logic        csrClr,
   output logic        txIrq
);

   // Transmit interrupt enable
   logic tie;
   // CLR requested by this write
   logic clrReq;

   assign clrReq = wrStb.csrWr & wrStb.lo & wrStb.data[csrClrBit];

   ////////////////////////////////////////
   // CSR storage
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mse    <= 1'b0;
         tie    <= 1'b0;
         csrClr <= 1'b0;
         txIrq  <= 1'b0;
      end
      else if (devReset)
      begin
         // Device reset clears the whole CSR
         mse    <= 1'b0;
         tie    <= 1'b0;
         csrClr <= 1'b0;
         txIrq  <= 1'b0;
      end
      else
      begin
         // One-cycle clear pulse, cycle after the write
         csrClr <= clrReq;

         if (csrClr)
         begin
            // Clear pulse wins over a write
            mse <= 1'b0;
            tie <= 1'b0;
         end
         else if (wrStb.csrWr)
         begin
            // MSE in low byte
            if (wrStb.lo)
            begin
               mse <= wrStb.data[csrMseBit];
            end
            // TIE in high byte
            if (wrStb.hi)
            begin
               tie <= wrStb.data[csrTieBit];
            end
         end

         // Interrupt is TIE and TRDY, dropped during clear
         txIrq <= tie & scan.trdy & ~csrClr;
      end
   end

   ////////////////////////////////////////
   // Read value
   ////////////////////////////////////////

   always_comb
   begin
      regCsr                            = 16'h0000;
      regCsr[csrMseBit]                 = mse;
      // CLR always reads zero
      regCsr[csrClrBit]                 = 1'b0;
      regCsr[csrTlineLsb +: lineW]      = scan.tline;
      regCsr[csrTieBit]                 = tie;
      regCsr[csrTrdyBit]                = scan.trdy;
   end

endmodule

/* rtl/dzTcr.sv */
// DZ11 Transmit Control Register
// DTR in the high byte, line enables in the low byte; CSR clear keeps DTR

`timescale 1ns/1ns

module dzTcr import dzPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        devReset,
   input  logic        csrClr,
   input  dzWrStrobes  wrStb,
   output logic [15:0] regTcr,
   output logic [7:0]  lineEn
);

   // Data terminal ready per line
   logic [7:0] tcrDtr;
   // Line enables (LIN)
   logic [7:0] tcrLin;

   // Priority: device reset, then clear, then write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         tcrDtr <= 8'h00;
         tcrLin <= 8'h00;
      end
      else if (devReset)
      begin
         tcrDtr <= 8'h00;
         tcrLin <= 8'h00;
      end
      else if (csrClr)
      begin
         // DTR survives a CSR clear
         tcrLin <= 8'h00;
      end
      else if (wrStb.tcrWr)
      begin
         if (wrStb.hi)
         begin
            tcrDtr <= wrStb.data[15:8];
         end
         if (wrStb.lo)
         begin
            tcrLin <= wrStb.data[7:0];
         end
      end
   end

   assign regTcr = {tcrDtr, tcrLin};
   assign lineEn = tcrLin;

endmodule

/* rtl/dzTxScan.sv */
// DZ11 transmit scanner
// Per-line busy timers, round-robin search for a ready line, char strobe

`timescale 1ns/1ns

module dzTxScan import dzPkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                devReset,
   input  logic                csrClr,
   input  logic                mse,
   input  logic [numLines-1:0] lineEn,
   input  dzWrStrobes          wrStb,
   output dzScanStat           scan,
   output dzTxChar             txOut
);

   logic [cntW-1:0]     busyCnt [numLines];
   // Last line serviced
   logic [lineW-1:0]    lastLine;
   logic [lineW-1:0]    nextLast;
   logic [numLines-1:0] ready;
   logic [numLines-1:0] readyNext;
   logic                accept;
   logic                selOk;
   logic [lineW-1:0]    selLine;

   ////////////////////////////////////////
   // Ready lines and accept
   ////////////////////////////////////////

   always_comb
   begin
      for (int i = 0; i < numLines; i++)
      begin
         ready[i] = mse & lineEn[i] & (busyCnt[i] == '0);
      end
   end

   // TDR write taken only if the reported line is still ready
   assign accept = wrStb.tdrWr & scan.trdy & ready[scan.tline] & ~csrClr & ~devReset;

   // Look ahead past this edge: serviced line goes busy, clears drop all
   always_comb
   begin
      nextLast = accept ? scan.tline : lastLine;
      for (int i = 0; i < numLines; i++)
      begin
         readyNext[i] = ready[i] & ~(accept && (scan.tline == lineW'(i)))
                        & ~csrClr & ~devReset;
      end
   end

   // Round robin, first ready line after the last one serviced
   always_comb
   begin
      logic [lineW-1:0] idx;
      selOk   = 1'b0;
      selLine = nextLast;
      // Descending so the nearest line is picked last
      for (int k = numLines; k >= 1; k--)
      begin
         idx = nextLast + lineW'(k);
         if (readyNext[idx])
         begin
            selOk   = 1'b1;
            selLine = idx;
         end
      end
   end

   ////////////////////////////////////////
   // Timers, pointer, status and strobe
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         for (int i = 0; i < numLines; i++)
         begin
            busyCnt[i] <= '0;
         end
         // Search starts at line 0
         lastLine <= lineW'(numLines - 1);
         scan     <= '0;
         txOut    <= '0;
      end
      else
      begin
         for (int i = 0; i < numLines; i++)
         begin
            if (devReset || csrClr)
               busyCnt[i] <= '0;
            else if (accept && (scan.tline == lineW'(i)))
               busyCnt[i] <= cntW'(charTime);
            else if (busyCnt[i] != '0)
               busyCnt[i] <= busyCnt[i] - 1'b1;
         end

         if (devReset)
            lastLine <= lineW'(numLines - 1);
         else
            lastLine <= nextLast;

         scan.trdy  <= selOk;
         scan.tline <= selLine;

         // One-cycle character strobe
         txOut.valid <= accept;
         if (accept)
         begin
            txOut.line <= scan.tline;
            txOut.chr  <= wrStb.data[7:0];
         end
      end
   end

endmodule

/* rtl/dzTop.sv */
// DZ11-style transmit multiplexer top level
// Bus decoder, CSR, TCR and round-robin transmit scanner

`timescale 1ns/1ns

module dzTop import dzPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        devReset,
   input  dzBusReq     busReq,
   output logic [15:0] rdData,
   output dzTxChar     txOut,
   output logic        txIrq
);

   dzWrStrobes          wrStb;
   dzScanStat           scan;
   logic [15:0]         regCsr;
   logic [15:0]         regTcr;
   logic                mse;
   logic                csrClr;
   logic [numLines-1:0] lineEn;

   // Bus facing decode and read mux
   dzDecode dzDecode_inst (
      .clk    (clk),
      .rst    (rst),
      .busReq (busReq),
      .regCsr (regCsr),
      .regTcr (regTcr),
      .wrStb  (wrStb),
      .rdData (rdData)
   );

   dzCsr dzCsr_inst (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .wrStb    (wrStb),
      .scan     (scan),
      .regCsr   (regCsr),
      .mse      (mse),
      .csrClr   (csrClr),
      .txIrq    (txIrq)
   );

   dzTcr dzTcr_inst (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .csrClr   (csrClr),
      .wrStb    (wrStb),
      .regTcr   (regTcr),
      .lineEn   (lineEn)
   );

   // Transmit scanner
   dzTxScan dzTxScan_inst (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .csrClr   (csrClr),
      .mse      (mse),
      .lineEn   (lineEn),
      .wrStb    (wrStb),
      .scan     (scan),
      .txOut    (txOut)
   );

endmodule

/* verif/dzTop_assertions.sv */
// DZ11 transmit multiplexer port assertions
// Strobe width, irq gated by MSE, idle read data

`timescale 1ns/1ns

module dzTop_assertions import dzPkg::*;
(
   input logic        clk,
   input logic        rst,
   input logic        mse,
   input dzBusReq     busReq,
   input logic [15:0] rdData,
   input dzTxChar     txOut,
   input logic        txIrq
);

   // MSE set at some point since reset
   logic mseSeen;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mseSeen <= 1'b0;
      end
      else if (mse)
      begin
         mseSeen <= 1'b1;
      end
   end

   // Character strobe lasts one cycle
   strobeOneCycle: assert property (@(posedge clk) disable iff (rst)
      txOut.valid |=> !txOut.valid)
      else $error("txOut.valid high on two consecutive cycles");

   irqNeedsMse: assert property (@(posedge clk) disable iff (rst)
      $rose(txIrq) |-> mseSeen)
      else $error("txIrq rose before MSE was ever set");

   // Read mux idles at zero
   idleReadZero: assert property (@(posedge clk) disable iff (rst)
      !busReq.rd |-> (rdData == 16'h0000))
      else $error("rdData nonzero with rd low");

endmodule

/* verif/dzTop_tb.sv */
// DZ11 transmit multiplexer testbench
// Directed tests for register access, clearing, round-robin transmit and irq

`timescale 1ns/1ns

module dzTop_tb import dzPkg::*;
();

   ////////////////////////////////////////
   // Run length
   ////////////////////////////////////////

   // Generous per-test cycle bounds
   localparam int resetCycles = 5;
   localparam int lenReset    = 30;
   localparam int lenLanes    = 80;
   localparam int lenClear    = 60;
   localparam int lenRobin    = 250;
   localparam int lenIgnore   = 120;
   localparam int lenIrq      = 120;
   localparam int cycleLimit  = resetCycles + lenReset + lenLanes + lenClear
                                + lenRobin + lenIgnore + lenIrq;

   // CSR control and status bits without TLINE
   localparam logic [15:0] cfgMask = (16'd1 << csrTieBit) | (16'd1 << csrMseBit)
                                     | (16'd1 << csrClrBit);
   localparam logic [15:0] ctlMask = cfgMask | (16'd1 << csrTrdyBit);

   logic        clk;
   logic        rst;
   logic        devReset;
   dzBusReq     busReq;
   logic [15:0] rdData;
   dzTxChar     txOut;
   logic        txIrq;

   int          errCount   = 0;
   int          checkCount = 0;
   int          cycles     = 0;
   logic [31:0] lfsr;
   // Every character strobe seen on txOut
   dzTxChar     txSeen [$];

   dzTop dzTop_inst (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .busReq   (busReq),
      .rdData   (rdData),
      .txOut    (txOut),
      .txIrq    (txIrq)
   );

   bind dzTop dzTop_assertions dzTop_assertions_inst (
      .clk    (clk),
      .rst    (rst),
      .mse    (mse),
      .busReq (busReq),
      .rdData (rdData),
      .txOut  (txOut),
      .txIrq  (txIrq)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Strobe capture away from the active edge
   always @(negedge clk)
   begin
      if (!rst && txOut.valid)
      begin
         txSeen.push_back(txOut);
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycleLimit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycleLimit);
         $display("Test failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [15:0] randWord();
      logic [15:0] w;
      w = '0;
      for (int i = 0; i < 16; i++)
      begin
         lfsr = lfsrNext(lfsr);
         w    = {w[14:0], lfsr[0]};
      end
      return w;
   endfunction

   // Next enabled line after prev in ascending order with wraparound
   function automatic logic [lineW-1:0] nextEnabled(input logic [lineW-1:0] prev,
                                                    input logic [numLines-1:0] lin);
      logic [lineW-1:0] idx;
      logic [lineW-1:0] result;
      logic             found;
      found  = 1'b0;
      result = prev;
      for (int k = 1; k <= numLines; k++)
      begin
         idx = lineW'((prev + k) % numLines);
         if (!found && lin[idx])
         begin
            found  = 1'b1;
            result = idx;
         end
      end
      return result;
   endfunction

   task automatic busWrite(input logic [1:0] addr, input logic [15:0] data,
                           input logic lo, input logic hi);
      dzBusReq req;
      req      = '0;
      req.wr   = 1'b1;
      req.lo   = lo;
      req.hi   = hi;
      req.addr = addr;
      req.data = data;
      @(posedge clk);
      busReq <= req;
      @(posedge clk);
      busReq <= '0;
   endtask

   task automatic busRead(input logic [1:0] addr, output logic [15:0] data);
      dzBusReq req;
      req      = '0;
      req.rd   = 1'b1;
      req.addr = addr;
      @(posedge clk);
      busReq <= req;
      @(negedge clk);
      data = rdData;
      @(posedge clk);
      busReq <= '0;
   endtask

   task automatic pulseDevReset();
      @(posedge clk);
      devReset <= 1'b1;
      @(posedge clk);
      devReset <= 1'b0;
   endtask

   // Read CSR until TRDY shows up
   task automatic pollTrdy(output logic [15:0] csr, output logic ok);
      ok = 1'b0;
      for (int n = 0; n < 40 && !ok; n++)
      begin
         busRead(regCsr, csr);
         ok = csr[csrTrdyBit];
      end
      if (!ok)
      begin
         errCount++;
         $display("TRDY never came up while polling the CSR at %0t", $time);
      end
   endtask

   // Strobe expected within a few cycles of the TDR write
   task automatic waitTx(output dzTxChar got, output logic ok);
      ok  = 1'b0;
      got = '0;
      for (int n = 0; n < 6 && !ok; n++)
      begin
         @(posedge clk);
         if (txSeen.size() > 0)
         begin
            got = txSeen.pop_front();
            ok  = 1'b1;
         end
      end
      if (!ok)
      begin
         errCount++;
         $display("No character strobe after an accepted TDR write at %0t", $time);
      end
   endtask

   task automatic expectNoTx(input string why);
      if (txSeen.size() != 0)
      begin
         errCount++;
         $display("Unexpected character strobe: %s", why);
         txSeen.delete();
      end
   endtask

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////

   task automatic checkWord(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
      checkCount++;
      if (got !== exp)
      begin
         errCount++;
         $display("ERROR: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic checkTx(input dzTxChar got, input dzTxChar exp);
      checkCount++;
      if (got !== exp)
      begin
         errCount++;
         $display("ERROR: txOut got 0x%h expected 0x%h at %0t", got, exp, $time);
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      checkCount++;
      if (got !== exp)
      begin
         errCount++;
         $display("ERROR: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic testResetState();
      logic [15:0] r;
      // TLINE has no meaning while TRDY is low
      busRead(regCsr, r);
      checkWord("rdData.csr", r & ctlMask, 16'h0000);
      busRead(regTcr, r);
      checkWord("rdData.tcr", r, 16'h0000);
      busRead(2'd1, r);
      checkWord("rdData.unused", r, 16'h0000);
      busRead(regTdr, r);
      checkWord("rdData.tdr", r, 16'h0000);
      @(negedge clk);
      checkBit("txIrq", txIrq, 1'b0);
      expectNoTx("after reset");
   endtask

   task automatic testTcrLanes();
      logic [7:0]  expDtr;
      logic [7:0]  expLin;
      logic [15:0] w;
      logic [15:0] r;
      expDtr = 8'h00;
      expLin = 8'h00;
      for (int n = 0; n < 3; n++)
      begin
         // Low lane only touches LIN
         w = randWord();
         busWrite(regTcr, w, 1'b1, 1'b0);
         expLin = w[7:0];
         busRead(regTcr, r);
         checkWord("rdData.tcr", r, {expDtr, expLin});
         // High lane only touches DTR
         w = randWord();
         busWrite(regTcr, w, 1'b0, 1'b1);
         expDtr = w[15:8];
         busRead(regTcr, r);
         checkWord("rdData.tcr", r, {expDtr, expLin});
         w = randWord();
         busWrite(regTcr, w, 1'b1, 1'b1);
         {expDtr, expLin} = w;
         busRead(regTcr, r);
         checkWord("rdData.tcr", r, {expDtr, expLin});
      end
   endtask

   task automatic testClear();
      logic [15:0] w;
      logic [15:0] r;
      w = randWord();
      busWrite(regTcr, w, 1'b1, 1'b1);
      busWrite(regCsr, cfgMask & ~(16'd1 << csrClrBit), 1'b1, 1'b1);
      busRead(regCsr, r);
      checkWord("rdData.csr", r & cfgMask, cfgMask & ~(16'd1 << csrClrBit));
      // CLR with MSE in the same byte still clears MSE
      busWrite(regCsr, (16'd1 << csrClrBit) | (16'd1 << csrMseBit), 1'b1, 1'b0);
      busRead(regCsr, r);
      checkWord("rdData.csr", r & ctlMask, 16'h0000);
      busRead(regTcr, r);
      checkWord("rdData.tcr", r, {w[15:8], 8'h00});
      expectNoTx("during CSR clear");
      // Device reset takes DTR too
      busWrite(regCsr, 16'd1 << csrMseBit, 1'b1, 1'b0);
      pulseDevReset();
      busRead(regTcr, r);
      checkWord("rdData.tcr", r, 16'h0000);
      busRead(regCsr, r);
      checkWord("rdData.csr", r & ctlMask, 16'h0000);
   endtask

   task automatic testRoundRobin();
      logic [numLines-1:0] lin;
      logic [lineW-1:0]    prevLine;
      logic [lineW-1:0]    expLine;
      logic [15:0]         csr;
      logic [15:0]         w;
      logic                ok;
      dzTxChar             got;
      dzTxChar             exp;
      // Lines 1, 3 and 6
      lin = 8'b0100_1010;
      pulseDevReset();
      txSeen.delete();
      // Nothing serviced yet so the search starts at line 0
      prevLine = lineW'(numLines - 1);
      busWrite(regTcr, {8'h00, lin}, 1'b1, 1'b0);
      busWrite(regCsr, 16'd1 << csrMseBit, 1'b1, 1'b0);
      for (int n = 0; n < 6; n++)
      begin
         expLine = nextEnabled(prevLine, lin);
         pollTrdy(csr, ok);
         if (!ok)
         begin
            return;
         end
         checkWord("rdData.tline", 16'(csr[csrTlineLsb +: lineW]), 16'(expLine));
         // High byte must not reach the line
         w = randWord();
         busWrite(regTdr, w, 1'b1, 1'b1);
         waitTx(got, ok);
         exp.valid = 1'b1;
         exp.line  = expLine;
         exp.chr   = w[7:0];
         if (ok)
         begin
            checkTx(got, exp);
         end
         prevLine = expLine;
      end
   endtask

   task automatic testIgnoredWrites();
      logic [15:0] csr;
      logic [15:0] w;
      logic        ok;
      dzTxChar     got;
      dzTxChar     exp;
      txSeen.delete();
      busWrite(regTcr, 16'h0004, 1'b1, 1'b0);
      busWrite(regCsr, 16'd1 << csrMseBit, 1'b1, 1'b0);
      pollTrdy(csr, ok);
      w = randWord();
      busWrite(regTdr, w, 1'b1, 1'b0);
      // Line 2 now busy with TRDY low
      busWrite(regTdr, ~w, 1'b1, 1'b0);
      waitTx(got, ok);
      exp.valid = 1'b1;
      exp.line  = 3'd2;
      exp.chr   = w[7:0];
      if (ok)
      begin
         checkTx(got, exp);
      end
      repeat (4) @(posedge clk);
      expectNoTx("TDR write with TRDY low");
      // Idle line but MSE off
      pollTrdy(csr, ok);
      busWrite(regCsr, 16'h0000, 1'b1, 1'b0);
      busRead(regCsr, csr);
      checkWord("rdData.csr", csr & ctlMask, 16'h0000);
      busWrite(regTdr, randWord(), 1'b1, 1'b0);
      repeat (4) @(posedge clk);
      expectNoTx("TDR write with MSE clear");
   endtask

   task automatic testIrq();
      logic [15:0] csr;
      logic        ok;
      dzTxChar     got;
      txSeen.delete();
      busWrite(regTcr, 16'h0001, 1'b1, 1'b0);
      busWrite(regCsr, (16'd1 << csrTieBit) | (16'd1 << csrMseBit), 1'b1, 1'b1);
      pollTrdy(csr, ok);
      @(negedge clk);
      checkBit("txIrq", txIrq, 1'b1);
      // Line 0 goes busy and the irq follows TRDY down
      busWrite(regTdr, randWord(), 1'b1, 1'b0);
      busRead(regCsr, csr);
      checkWord("rdData.csr", csr & ctlMask, (16'd1 << csrTieBit) | (16'd1 << csrMseBit));
      @(negedge clk);
      checkBit("txIrq", txIrq, 1'b0);
      waitTx(got, ok);
      pollTrdy(csr, ok);
      @(negedge clk);
      checkBit("txIrq", txIrq, 1'b1);
      // TIE off with MSE kept
      busWrite(regCsr, 16'd1 << csrMseBit, 1'b1, 1'b1);
      busRead(regCsr, csr);
      checkWord("rdData.csr", csr & ctlMask, (16'd1 << csrTrdyBit) | (16'd1 << csrMseBit));
      @(negedge clk);
      checkBit("txIrq", txIrq, 1'b0);
   endtask

   ////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////

   initial
   begin
      rst      = 1'b1;
      devReset = 1'b0;
      busReq   = '0;
      lfsr     = 32'h6ae56458;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
      testResetState();
      testTcrLanes();
      testClear();
      testRoundRobin();
      testIgnoredWrites();
      testIrq();
      repeat (2) @(posedge clk);
      $display("Checks run: %0d, errors: %0d", checkCount, errCount);
      if (errCount == 0)
      begin
         $display("Test passed");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* dzTop.f */
rtl/dzPkg.sv
rtl/dzDecode.sv
rtl/dzCsr.sv
rtl/dzTcr.sv
rtl/dzTxScan.sv
rtl/dzTop.sv
verif/dzTop_assertions.sv
verif/dzTop_tb.sv
